// File: exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// Data path width
`define EXU_XLEN 32

// Address width seen by the AGU
`define EXU_ADDR_SIZE 32

// Destination register index width
`define EXU_RIDX_W 5

`endif

// File: exu_op_pkg.sv
package exu_op_pkg;

  // Which sub-unit owns the instruction
  typedef enum logic [1:0] {
    GRP_ALU      = 2'd0,
    GRP_BJP      = 2'd1,
    GRP_AGU      = 2'd2,
    GRP_IFU_EXCP = 2'd3  // Fetch side exception, no unit runs
  } grp_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU, ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU, BJP_JAL, BJP_JALR
  } bjp_op_e;

  typedef enum logic [1:0] {
    AGU_SIZE_B = 2'd0,
    AGU_SIZE_H = 2'd1,
    AGU_SIZE_W = 2'd2
  } agu_size_e;

  // Function carried out by the shared datapath
  typedef enum logic [3:0] {
    DP_ADD, DP_SUB, DP_XOR, DP_SLL, DP_SRL, DP_SRA,
    DP_OR, DP_AND, DP_SLT, DP_SLTU, DP_PASS2
  } dpath_op_e;

  typedef struct packed {
    logic [7:0] pad;
    logic       wfi;
    logic       ebreak;
    logic       ecall;
    logic       op2imm;  // Op2 from imm instead of rs2
    alu_op_e    op;
  } alu_info_t;

  typedef struct packed {
    logic [11:0] pad;
    logic        prdt_taken;  // Front end guessed taken
    bjp_op_e     op;
  } bjp_info_t;

  typedef struct packed {
    logic [12:0] pad;
    logic        ld;  // Set for load, clear for store
    agu_size_e   size;
  } agu_info_t;

  // Same 16-bit info word, read according to the group
  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
    agu_info_t agu;
  } exu_info_u;

endpackage

// File: exu_port_pkg.sv
`include "exu_macros.svh"

package exu_port_pkg;
  import exu_op_pkg::*;

  // Decoded instruction from issue
  typedef struct packed {
    logic [`EXU_ADDR_SIZE-1:0] pc;
    logic [`EXU_XLEN-1:0]      rs1;
    logic [`EXU_XLEN-1:0]      rs2;
    logic [`EXU_XLEN-1:0]      imm;
    grp_e                      grp;
    exu_info_u                 info;
    logic [`EXU_RIDX_W-1:0]    rdidx;
    logic                      rdwen;
    logic                      ilegl;
  } exu_req_t;

  typedef struct packed {
    logic                 req;  // Strobe, one unit at a time
    dpath_op_e            op;
    logic [`EXU_XLEN-1:0] op1;
    logic [`EXU_XLEN-1:0] op2;
  } dpath_req_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] res;
    logic                 eq;
    logic                 lt;
    logic                 ltu;
  } dpath_res_t;

  // What one sub-unit hands to the control module
  typedef struct packed {
    logic [`EXU_XLEN-1:0]      wdat;
    logic                      err;
    logic                      bjp;
    logic                      prdt;
    logic                      rslv;
    logic                      ecall;
    logic                      ebreak;
    logic                      wfi;
    logic                      misalgn;
    logic                      ld;
    logic [`EXU_ADDR_SIZE-1:0] badaddr;
  } unit_res_t;

  typedef struct packed {
    logic [`EXU_ADDR_SIZE-1:0] pc;
    logic                      err;
    logic                      bjp;
    logic                      prdt;
    logic                      rslv;
    logic                      ecall;
    logic                      ebreak;
    logic                      wfi;
    logic                      misalgn;
    logic                      ld;
    logic [`EXU_ADDR_SIZE-1:0] badaddr;
    logic                      ilegl;
  } cmt_t;

  typedef struct packed {
    logic [`EXU_RIDX_W-1:0] rdidx;
    logic [`EXU_XLEN-1:0]   wdat;
  } wbck_t;

endpackage

// File: exu_alu_dpath.sv
`timescale 1ns/1ns
`include "exu_macros.svh"

module exu_alu_dpath
  import exu_op_pkg::*;
  import exu_port_pkg::*;
(
  input  dpath_req_t i_rglr_req,
  input  dpath_req_t i_bjp_req,
  input  dpath_req_t i_agu_req,
  output dpath_res_t o_res
);

  localparam int REQ_W = $bits(dpath_req_t);
  localparam int SHW   = $clog2(`EXU_XLEN);

  dpath_req_t           mrg;
  logic [`EXU_XLEN-1:0] op1;
  logic [`EXU_XLEN-1:0] op2;
  logic [`EXU_XLEN-1:0] add_res;
  logic [`EXU_XLEN:0]   sub_wide;  // Extra bit keeps the unsigned borrow
  logic [`EXU_XLEN-1:0] xor_res;
  logic [SHW-1:0]       shamt;
  logic                 ltu;
  logic                 lt;

  // Each request only counts while its own strobe is up
  assign mrg = dpath_req_t'(({REQ_W{i_rglr_req.req}} & i_rglr_req)
                          | ({REQ_W{i_bjp_req.req}}  & i_bjp_req)
                          | ({REQ_W{i_agu_req.req}}  & i_agu_req));

  assign op1 = mrg.op1;
  assign op2 = mrg.op2;

  assign add_res  = op1 + op2;
  assign sub_wide = {1'b0, op1} - {1'b0, op2};
  assign xor_res  = op1 ^ op2;
  assign shamt    = op2[SHW-1:0];

  assign ltu = sub_wide[`EXU_XLEN];
  // Signs differ means the negative one is smaller
  assign lt  = (op1[`EXU_XLEN-1] ^ op2[`EXU_XLEN-1]) ? op1[`EXU_XLEN-1] : ltu;

  always_comb begin
    case (mrg.op)
      DP_ADD:   o_res.res = add_res;
      DP_SUB:   o_res.res = sub_wide[`EXU_XLEN-1:0];
      DP_XOR:   o_res.res = xor_res;
      DP_SLL:   o_res.res = op1 << shamt;
      DP_SRL:   o_res.res = op1 >> shamt;
      DP_SRA:   o_res.res = $signed(op1) >>> shamt;
      DP_OR:    o_res.res = op1 | op2;
      DP_AND:   o_res.res = op1 & op2;
      DP_SLT:   o_res.res = {{(`EXU_XLEN-1){1'b0}}, lt};
      DP_SLTU:  o_res.res = {{(`EXU_XLEN-1){1'b0}}, ltu};
      DP_PASS2: o_res.res = op2;  // LUI
      default:  o_res.res = '0;
    endcase
  end

  // Compare flags go out whatever the function
  assign o_res.eq  = ~|xor_res;
  assign o_res.lt  = lt;
  assign o_res.ltu = ltu;

  always_comb begin
    assert ($onehot0({i_rglr_req.req, i_bjp_req.req, i_agu_req.req}))
      else $error("exu_alu_dpath: more than one unit requests the datapath");
  end

endmodule

// File: exu_alu_rglr.sv
`timescale 1ns/1ns
`include "exu_macros.svh"

module exu_alu_rglr
  import exu_op_pkg::*;
  import exu_port_pkg::*;
(
  input  logic       i_en,
  input  exu_req_t   i_req,
  input  dpath_res_t i_dres,
  output dpath_req_t o_dreq,
  output unit_res_t  o_res
);

  alu_info_t            info;
  logic                 use_imm;
  logic [`EXU_XLEN-1:0] op2;

  assign info    = i_req.info.alu;
  assign use_imm = info.op2imm | (info.op == ALU_LUI);  // LUI always takes imm
  assign op2     = use_imm ? i_req.imm : i_req.rs2;

  always_comb begin
    o_dreq     = '0;
    o_dreq.req = i_en;
    o_dreq.op1 = i_req.rs1;
    o_dreq.op2 = op2;
    case (info.op)
      ALU_ADD:  o_dreq.op = DP_ADD;
      ALU_SUB:  o_dreq.op = DP_SUB;
      ALU_XOR:  o_dreq.op = DP_XOR;
      ALU_SLL:  o_dreq.op = DP_SLL;
      ALU_SRL:  o_dreq.op = DP_SRL;
      ALU_SRA:  o_dreq.op = DP_SRA;
      ALU_OR:   o_dreq.op = DP_OR;
      ALU_AND:  o_dreq.op = DP_AND;
      ALU_SLT:  o_dreq.op = DP_SLT;
      ALU_SLTU: o_dreq.op = DP_SLTU;
      ALU_LUI:  o_dreq.op = DP_PASS2;
      default:  o_dreq.op = DP_ADD;
    endcase
  end

  always_comb begin
    o_res        = '0;
    o_res.wdat   = i_dres.res;
    o_res.ecall  = info.ecall;   // System flags ride along to commit
    o_res.ebreak = info.ebreak;
    o_res.wfi    = info.wfi;
  end

endmodule

// File: exu_alu_bjp.sv
`timescale 1ns/1ns
`include "exu_macros.svh"

module exu_alu_bjp
  import exu_op_pkg::*;
  import exu_port_pkg::*;
(
  input  logic       i_en,
  input  exu_req_t   i_req,
  input  dpath_res_t i_dres,
  output dpath_req_t o_dreq,
  output unit_res_t  o_res
);

  bjp_info_t info;
  logic      is_jump;
  logic      taken;

  assign info    = i_req.info.bjp;
  assign is_jump = (info.op == BJP_JAL) || (info.op == BJP_JALR);

  // Jumps add pc and 4 for the link, branches subtract for the flags
  always_comb begin
    o_dreq     = '0;
    o_dreq.req = i_en;
    if (is_jump) begin
      o_dreq.op  = DP_ADD;
      o_dreq.op1 = `EXU_XLEN'(i_req.pc);
      o_dreq.op2 = `EXU_XLEN'(4);
    end else begin
      o_dreq.op  = DP_SUB;
      o_dreq.op1 = i_req.rs1;
      o_dreq.op2 = i_req.rs2;
    end
  end

  always_comb begin
    case (info.op)
      BJP_BEQ:  taken = i_dres.eq;
      BJP_BNE:  taken = ~i_dres.eq;
      BJP_BLT:  taken = i_dres.lt;
      BJP_BGE:  taken = ~i_dres.lt;
      BJP_BLTU: taken = i_dres.ltu;
      BJP_BGEU: taken = ~i_dres.ltu;
      default:  taken = 1'b1;  // JAL and JALR
    endcase
  end

  always_comb begin
    o_res      = '0;
    o_res.wdat = i_dres.res;  // Link value for jumps
    o_res.bjp  = 1'b1;
    o_res.prdt = info.prdt_taken;
    o_res.rslv = taken;  // Commit compares this against prdt
  end

endmodule

// File: exu_alu_agu.sv
`timescale 1ns/1ns
`include "exu_macros.svh"

module exu_alu_agu
  import exu_op_pkg::*;
  import exu_port_pkg::*;
(
  input  logic       i_en,
  input  exu_req_t   i_req,
  input  dpath_res_t i_dres,
  output dpath_req_t o_dreq,
  output unit_res_t  o_res
);

  agu_info_t                 info;
  logic [`EXU_ADDR_SIZE-1:0] addr;
  logic                      misalgn;

  assign info = i_req.info.agu;

  // Effective address is rs1 plus offset
  always_comb begin
    o_dreq     = '0;
    o_dreq.req = i_en;
    o_dreq.op  = DP_ADD;
    o_dreq.op1 = i_req.rs1;
    o_dreq.op2 = i_req.imm;
  end

  assign addr = i_dres.res[`EXU_ADDR_SIZE-1:0];

  always_comb begin
    case (info.size)
      AGU_SIZE_B: misalgn = 1'b0;
      AGU_SIZE_H: misalgn = addr[0];
      AGU_SIZE_W: misalgn = |addr[1:0];
      default:    misalgn = |addr[1:0];  // Unused code, checked as word
    endcase
  end

  always_comb begin
    o_res         = '0;
    o_res.err     = misalgn;
    o_res.misalgn = misalgn;
    o_res.ld      = info.ld;
    o_res.badaddr = addr;  // Reported even when aligned
  end

endmodule

// File: exu_alu_ctrl.sv
`timescale 1ns/1ns

module exu_alu_ctrl
  import exu_op_pkg::*;
  import exu_port_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_valid,
  output logic      o_ready,
  input  exu_req_t  i_req,
  output logic      o_en_rglr,
  output logic      o_en_bjp,
  output logic      o_en_agu,
  input  unit_res_t i_rglr_res,
  input  unit_res_t i_bjp_res,
  input  unit_res_t i_agu_res,
  output logic      o_cmt_valid,
  input  logic      i_cmt_ready,
  output cmt_t      o_cmt,
  output logic      o_wbck_valid,
  input  logic      i_wbck_ready,
  output wbck_t     o_wbck
);

  localparam int RES_W = $bits(unit_res_t);

  logic      ifu_excp;
  unit_res_t sel_res;
  logic      err;
  logic      need_wbck;
  logic      accept;
  cmt_t      cmt_nxt;
  wbck_t     wbck_nxt;
  logic      cmt_pend;
  logic      wbck_pend;
  cmt_t      cmt_q;
  wbck_t     wbck_q;

  assign o_en_rglr = (i_req.grp == GRP_ALU);
  assign o_en_bjp  = (i_req.grp == GRP_BJP);
  assign o_en_agu  = (i_req.grp == GRP_AGU);
  assign ifu_excp  = (i_req.grp == GRP_IFU_EXCP);

  // AND-OR select, nothing gets through for a fetch exception
  assign sel_res = unit_res_t'(({RES_W{o_en_rglr}} & i_rglr_res)
                             | ({RES_W{o_en_bjp}}  & i_bjp_res)
                             | ({RES_W{o_en_agu}}  & i_agu_res));

  assign err       = i_req.ilegl | ifu_excp | sel_res.err;
  assign need_wbck = i_req.rdwen & ~err & (o_en_rglr | o_en_bjp);

  always_comb begin
    cmt_nxt.pc      = i_req.pc;
    cmt_nxt.err     = err;
    cmt_nxt.bjp     = sel_res.bjp;
    cmt_nxt.prdt    = sel_res.prdt;
    cmt_nxt.rslv    = sel_res.rslv;
    cmt_nxt.ecall   = sel_res.ecall;
    cmt_nxt.ebreak  = sel_res.ebreak;
    cmt_nxt.wfi     = sel_res.wfi;
    cmt_nxt.misalgn = sel_res.misalgn;
    cmt_nxt.ld      = sel_res.ld;
    cmt_nxt.badaddr = sel_res.badaddr;
    cmt_nxt.ilegl   = i_req.ilegl | ifu_excp;
  end

  assign wbck_nxt.rdidx = i_req.rdidx;
  assign wbck_nxt.wdat  = sel_res.wdat;

  // Free when every pending side is empty or leaving now
  assign o_ready = (~cmt_pend | i_cmt_ready) & (~wbck_pend | i_wbck_ready);
  assign accept  = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      cmt_pend  <= 1'b0;
      wbck_pend <= 1'b0;
    end else if (accept) begin
      cmt_pend  <= 1'b1;       // Commit always needed
      wbck_pend <= need_wbck;
    end else begin
      if (i_cmt_ready) cmt_pend <= 1'b0;
      if (i_wbck_ready) wbck_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmt_q  <= cmt_nxt;
      wbck_q <= wbck_nxt;
    end
  end

  assign o_cmt_valid  = cmt_pend;
  assign o_wbck_valid = wbck_pend;
  assign o_cmt        = cmt_q;
  assign o_wbck       = wbck_q;

  assert property (@(posedge clk) disable iff (i_reset)
    (o_cmt_valid && !i_cmt_ready) |=> (o_cmt_valid && $stable(o_cmt)))
    else $error("exu_alu_ctrl: commit record changed while stalled");

  assert property (@(posedge clk) disable iff (i_reset)
    accept |=> (o_cmt_valid || !o_wbck_valid))
    else $error("exu_alu_ctrl: writeback loaded without a commit");

endmodule

// File: exu_alu_top.sv
`timescale 1ns/1ns

module exu_alu_top
  import exu_port_pkg::*;
(
  input  logic     clk,
  input  logic     i_reset,
  input  logic     i_valid,
  output logic     o_ready,
  input  exu_req_t i_req,
  output logic     o_cmt_valid,
  input  logic     i_cmt_ready,
  output cmt_t     o_cmt,
  output logic     o_wbck_valid,
  input  logic     i_wbck_ready,
  output wbck_t    o_wbck
);

  logic       en_rglr;
  logic       en_bjp;
  logic       en_agu;
  dpath_req_t rglr_dreq;
  dpath_req_t bjp_dreq;
  dpath_req_t agu_dreq;
  dpath_res_t dres;
  unit_res_t  rglr_res;
  unit_res_t  bjp_res;
  unit_res_t  agu_res;

  exu_alu_ctrl u_ctrl (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_req        (i_req),
    .o_en_rglr    (en_rglr),
    .o_en_bjp     (en_bjp),
    .o_en_agu     (en_agu),
    .i_rglr_res   (rglr_res),
    .i_bjp_res    (bjp_res),
    .i_agu_res    (agu_res),
    .o_cmt_valid  (o_cmt_valid),
    .i_cmt_ready  (i_cmt_ready),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck       (o_wbck)
  );

  exu_alu_rglr u_rglr (
    .i_en   (en_rglr),
    .i_req  (i_req),
    .i_dres (dres),
    .o_dreq (rglr_dreq),
    .o_res  (rglr_res)
  );

  exu_alu_bjp u_bjp (
    .i_en   (en_bjp),
    .i_req  (i_req),
    .i_dres (dres),
    .o_dreq (bjp_dreq),
    .o_res  (bjp_res)
  );

  exu_alu_agu u_agu (
    .i_en   (en_agu),
    .i_req  (i_req),
    .i_dres (dres),
    .o_dreq (agu_dreq),
    .o_res  (agu_res)
  );

  // One adder and shifter shared by all three units
  exu_alu_dpath u_dpath (
    .i_rglr_req (rglr_dreq),
    .i_bjp_req  (bjp_dreq),
    .i_agu_req  (agu_dreq),
    .o_res      (dres)
  );

endmodule

// File: tb_exu_alu.sv
`timescale 1ns/1ns
`include "exu_macros.svh"

module tb_exu_alu
  import exu_op_pkg::*;
  import exu_port_pkg::*;
();

  localparam int TIMEOUT = 200;  // Cycles per wait loop

  logic     clk = 1'b0;
  logic     i_reset;
  logic     i_valid;
  logic     o_ready;
  exu_req_t i_req;
  logic     o_cmt_valid;
  logic     i_cmt_ready;
  cmt_t     o_cmt;
  logic     o_wbck_valid;
  logic     i_wbck_ready;
  wbck_t    o_wbck;

  int    seed = 32'hf601;
  int    checks = 0;
  int    errors = 0;
  cmt_t  exp_cmt[$];
  wbck_t exp_wbck[$];
  cmt_t  got_cmt[$];
  wbck_t got_wbck[$];

  exu_alu_top uut (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_req        (i_req),
    .o_cmt_valid  (o_cmt_valid),
    .i_cmt_ready  (i_cmt_ready),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready),
    .o_wbck       (o_wbck)
  );

  always #20 clk = ~clk;

  // Transfers are seen mid cycle where valid and ready are settled
  always @(negedge clk) begin
    if (!i_reset && o_cmt_valid && i_cmt_ready) got_cmt.push_back(o_cmt);
    if (!i_reset && o_wbck_valid && i_wbck_ready) got_wbck.push_back(o_wbck);
  end

  // Reference model of one item
  function automatic void model(input exu_req_t r, output cmt_t c, output logic wb,
                                output wbck_t w);
    logic [`EXU_XLEN-1:0] b;
    logic [`EXU_XLEN-1:0] res;
    logic [`EXU_XLEN-1:0] addr;
    logic                 mis;
    logic                 err;
    c    = '0;
    res  = '0;
    mis  = 1'b0;
    case (r.grp)
      GRP_ALU: begin
        b = (r.info.alu.op2imm || r.info.alu.op == ALU_LUI) ? r.imm : r.rs2;
        case (r.info.alu.op)
          ALU_ADD:  res = r.rs1 + b;
          ALU_SUB:  res = r.rs1 - b;
          ALU_XOR:  res = r.rs1 ^ b;
          ALU_SLL:  res = r.rs1 << b[4:0];
          ALU_SRL:  res = r.rs1 >> b[4:0];
          ALU_SRA:  res = $signed(r.rs1) >>> b[4:0];
          ALU_OR:   res = r.rs1 | b;
          ALU_AND:  res = r.rs1 & b;
          ALU_SLT:  res = {31'b0, $signed(r.rs1) < $signed(b)};
          ALU_SLTU: res = {31'b0, r.rs1 < b};
          default:  res = b;  // LUI
        endcase
        c.ecall  = r.info.alu.ecall;
        c.ebreak = r.info.alu.ebreak;
        c.wfi    = r.info.alu.wfi;
      end
      GRP_BJP: begin
        c.bjp  = 1'b1;
        c.prdt = r.info.bjp.prdt_taken;
        case (r.info.bjp.op)
          BJP_BEQ:  c.rslv = (r.rs1 == r.rs2);
          BJP_BNE:  c.rslv = (r.rs1 != r.rs2);
          BJP_BLT:  c.rslv = ($signed(r.rs1) < $signed(r.rs2));
          BJP_BGE:  c.rslv = ($signed(r.rs1) >= $signed(r.rs2));
          BJP_BLTU: c.rslv = (r.rs1 < r.rs2);
          BJP_BGEU: c.rslv = (r.rs1 >= r.rs2);
          default: begin
            c.rslv = 1'b1;
            res    = r.pc + 32'd4;  // Link address
          end
        endcase
      end
      GRP_AGU: begin
        addr = r.rs1 + r.imm;
        case (r.info.agu.size)
          AGU_SIZE_B: mis = 1'b0;
          AGU_SIZE_H: mis = addr[0];
          default:    mis = |addr[1:0];
        endcase
        c.misalgn = mis;
        c.ld      = r.info.agu.ld;
        c.badaddr = addr;
      end
      default: ;
    endcase
    err     = r.ilegl | (r.grp == GRP_IFU_EXCP) | mis;
    c.pc    = r.pc;
    c.err   = err;
    c.ilegl = r.ilegl | (r.grp == GRP_IFU_EXCP);
    wb      = r.rdwen & ~err & (r.grp == GRP_ALU || r.grp == GRP_BJP);
    w.rdidx = r.rdidx;
    w.wdat  = res;
  endfunction

  function automatic exu_req_t base_req();
    exu_req_t    r;
    logic [31:0] t;
    r       = '0;
    r.pc    = $random(seed);
    r.pc[1:0] = 2'b00;
    r.rs1   = $random(seed);
    r.rs2   = $random(seed);
    r.imm   = $random(seed);
    t       = $random(seed);
    r.rdidx = t[4:0];
    r.grp   = GRP_ALU;
    r.rdwen = 1'b1;
    return r;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timed out at %0t waiting for %s", $time, what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic check_cmt(input string what, input cmt_t got, input cmt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s commit got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_wbck(input string what, input wbck_t got, input wbck_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s writeback got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Puts an item on the request port and queues what the model expects
  task automatic drive(input exu_req_t r);
    cmt_t  c;
    wbck_t w;
    logic  wb;
    model(r, c, wb, w);
    exp_cmt.push_back(c);
    if (wb) exp_wbck.push_back(w);
    @(posedge clk);
    i_valid <= 1'b1;
    i_req   <= r;
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!o_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!o_ready) abort_on_timeout("the DUT to accept an item");
    @(posedge clk);
    i_valid <= 1'b0;
  endtask

  task automatic send(input exu_req_t r);
    drive(r);
    wait_accept();
  endtask

  // Waits for all expected results and compares them in order
  task automatic collect();
    int    n;
    cmt_t  gc;
    cmt_t  ec;
    wbck_t gw;
    wbck_t ew;
    n = 0;
    while ((got_cmt.size() < exp_cmt.size() || got_wbck.size() < exp_wbck.size())
           && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (got_cmt.size() < exp_cmt.size() || got_wbck.size() < exp_wbck.size())
      abort_on_timeout("commit and writeback results");
    repeat (2) @(posedge clk);  // Catch any extra transfer
    if (got_cmt.size() != exp_cmt.size() || got_wbck.size() != exp_wbck.size()) begin
      errors++;
      $display("Wrong result count at %0t: got %0d commits, %0d writebacks, expected %0d, %0d",
               $time, got_cmt.size(), got_wbck.size(), exp_cmt.size(), exp_wbck.size());
    end
    while (got_cmt.size() > 0 && exp_cmt.size() > 0) begin
      gc = got_cmt.pop_front();
      ec = exp_cmt.pop_front();
      check_cmt("result", gc, ec);
    end
    while (got_wbck.size() > 0 && exp_wbck.size() > 0) begin
      gw = got_wbck.pop_front();
      ew = exp_wbck.pop_front();
      check_wbck("result", gw, ew);
    end
    got_cmt.delete();
    exp_cmt.delete();
    got_wbck.delete();
    exp_wbck.delete();
  endtask

  task automatic report(input string name, input int e0);
    $display("test %-12s errors %0d", name, errors - e0);
  endtask

  task automatic test_alu_ops();
    exu_req_t    r;
    logic [31:0] t;
    int          e0;
    e0 = errors;
    for (int k = 0; k < 11; k++) begin
      for (int m = 0; m < 3; m++) begin
        r = base_req();
        t = $random(seed);
        r.info.alu.op     = alu_op_e'(k[3:0]);
        r.info.alu.op2imm = (m == 1);
        r.rdwen           = (m != 2);  // Last pass commits only
        r.info.alu.ecall  = t[0];
        send(r);
      end
    end
    collect();
    report("alu_ops", e0);
  endtask

  task automatic test_branches();
    exu_req_t    r;
    logic [31:0] pa [4];
    logic [31:0] pb [4];
    logic [31:0] t;
    int          e0;
    e0 = errors;
    pa[0] = $random(seed);
    pb[0] = pa[0];          // Equal
    pa[1] = -32'sd5;
    pb[1] = 32'd3;          // Signed less only
    pa[2] = 32'd3;
    pb[2] = -32'sd5;        // Unsigned less only
    pa[3] = 32'd100;
    pb[3] = 32'd7;
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 4; p++) begin
        r = base_req();
        t = $random(seed);
        r.grp = GRP_BJP;
        r.info.bjp.op         = bjp_op_e'(k[2:0]);
        r.info.bjp.prdt_taken = t[0];
        r.rs1   = pa[p];
        r.rs2   = pb[p];
        r.rdwen = 1'b0;
        send(r);
      end
    end
    collect();
    report("branches", e0);
  endtask

  task automatic test_jumps();
    exu_req_t r;
    int       e0;
    e0 = errors;
    for (int k = 0; k < 4; k++) begin
      r = base_req();
      r.grp = GRP_BJP;
      r.info.bjp.op         = (k < 2) ? BJP_JAL : BJP_JALR;
      r.info.bjp.prdt_taken = k[0];
      send(r);
    end
    for (int k = 0; k < 3; k++) begin
      r = base_req();
      r.info.alu.op     = ALU_ADD;
      r.info.alu.ecall  = (k == 0);
      r.info.alu.ebreak = (k == 1);
      r.info.alu.wfi    = (k == 2);
      send(r);
    end
    collect();
    report("jumps", e0);
  endtask

  task automatic test_agu();
    exu_req_t r;
    int       e0;
    e0 = errors;
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off++) begin
        r = base_req();
        r.grp = GRP_AGU;
        r.info.agu.size = agu_size_e'(s[1:0]);
        r.info.agu.ld   = off[0];
        r.rs1[1:0] = 2'b00;
        r.imm      = off;
        send(r);  // Writeback is never expected
      end
    end
    collect();
    report("agu", e0);
  endtask

  task automatic test_exceptions();
    exu_req_t r;
    int       e0;
    e0 = errors;
    r = base_req();
    r.ilegl = 1'b1;
    send(r);
    r = base_req();
    r.grp = GRP_IFU_EXCP;
    send(r);
    r = base_req();
    r.grp = GRP_BJP;
    r.info.bjp.op = BJP_JAL;
    r.ilegl = 1'b1;
    send(r);
    collect();
    report("exceptions", e0);
  endtask

  task automatic test_cmt_stall();
    int   n;
    int   e0;
    e0 = errors;
    @(posedge clk);
    i_cmt_ready <= 1'b0;
    send(base_req());
    n = 0;
    @(negedge clk);
    while (!o_cmt_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!o_cmt_valid) abort_on_timeout("a commit under stall");
    drive(base_req());
    repeat (3) begin
      @(negedge clk);
      check_cmt("held", o_cmt, exp_cmt[0]);
      check_flag("ready during commit stall", o_ready, 1'b0);
    end
    @(posedge clk);
    i_cmt_ready <= 1'b1;
    wait_accept();
    collect();
    report("cmt_stall", e0);
  endtask

  task automatic test_wbck_stall();
    int e0;
    e0 = errors;
    @(posedge clk);
    i_cmt_ready  <= 1'b0;
    i_wbck_ready <= 1'b0;
    send(base_req());
    drive(base_req());
    repeat (2) begin
      @(negedge clk);
      check_flag("ready with both stalled", o_ready, 1'b0);
    end
    @(posedge clk);
    i_cmt_ready <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_flag("ready with writeback stalled", o_ready, 1'b0);
    end
    check_flag("commit drained", o_cmt_valid, 1'b0);
    @(posedge clk);
    i_wbck_ready <= 1'b1;
    wait_accept();
    collect();
    report("wbck_stall", e0);
  endtask

  task automatic test_stream();
    exu_req_t    r;
    logic [31:0] t;
    int          e0;
    e0 = errors;
    for (int i = 0; i < 9; i++) begin
      r = base_req();
      t = $random(seed);
      if (i % 3 == 1) begin
        r.grp = GRP_BJP;
        r.info.bjp.op = bjp_op_e'(t[2:0]);
        r.rdwen = (t[2:1] == 2'b11);  // Only JAL and JALR link
      end else if (i % 3 == 2) begin
        r.grp = GRP_AGU;
        r.info.agu.size = AGU_SIZE_B;
      end else begin
        r.info.alu.op = ALU_XOR;
      end
      drive(r);
      @(negedge clk);
      check_flag("ready in stream", o_ready, 1'b1);
    end
    @(posedge clk);
    i_valid <= 1'b0;
    collect();
    report("stream", e0);
  endtask

  initial begin
    i_reset      <= 1'b1;
    i_valid      <= 1'b0;
    i_req        <= '0;
    i_cmt_ready  <= 1'b1;
    i_wbck_ready <= 1'b1;
    repeat (3) @(posedge clk);
    i_reset <= 1'b0;
    @(negedge clk);
    check_flag("commit valid after reset", o_cmt_valid, 1'b0);
    check_flag("writeback valid after reset", o_wbck_valid, 1'b0);
    test_alu_ops();
    test_branches();
    test_jumps();
    test_agu();
    test_exceptions();
    test_cmt_stall();
    test_wbck_stall();
    test_stream();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
exu_op_pkg.sv
exu_port_pkg.sv
exu_alu_dpath.sv
exu_alu_rglr.sv
exu_alu_bjp.sv
exu_alu_agu.sv
exu_alu_ctrl.sv
exu_alu_top.sv
tb_exu_alu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exu_alu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
